// ==== Makefile ====
.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f ifetch.f --top-module ifetch_tb

obj_dir/ifetch_tb: ifetch.f src/*.sv bench/*.sv bench/*.svh
	verilator --binary --timing --assert -j 0 -f ifetch.f --top-module ifetch_tb -o ifetch_tb

sim: obj_dir/ifetch_tb
	./obj_dir/ifetch_tb > sim.log 2>&1; status=$$?; cat sim.log; \
	if [ $$status -ne 0 ] || grep -q "Testbench failed" sim.log; then exit 1; fi

clean:
	rm -rf obj_dir sim.log

// ==== bench/ifetch_tb_checks.svh ====
`ifndef IFETCH_TB_CHECKS_SVH
`define IFETCH_TB_CHECKS_SVH

`default_nettype none

////////////////////
// Drive helpers
////////////////////

// Next rising edge, then the drive offset
task automatic tick();
   @(posedge clk);
   #10;
endtask

// Packet expected for a fetch at pc
function automatic if_id_t make_pkt(input word_t pc);
   if_id_t p;
   p.valid = 1'b1;
   p.pc    = pc;
   p.pc4   = pc + 32'd4;
   p.inst  = img[pc[6:2]];
   return p;
endfunction

// Kind bits are branch, zero, jump, jalr
function automatic ex_mem_redirect_t make_redirect(
   input logic [3:0] kind,
   input word_t      alu,
   input word_t      imm,
   input word_t      mpc
);
   ex_mem_redirect_t rd;
   rd.branch     = kind[3];
   rd.zero       = kind[2];
   rd.jump       = kind[1];
   rd.jalr       = kind[0];
   rd.alu_result = alu;
   rd.imm32      = imm;
   rd.mem_pc     = mpc;
   return rd;
endfunction

// Step until a valid packet shows up
task automatic wait_valid(input int limit);
   int n;
   n = 0;
   while (!fetch.valid && n < limit) begin
      tick();
      n++;
   end
   if (!fetch.valid) begin
      error_count++;
      $display("Timeout: no valid fetch packet within %0d cycles", limit);
   end
endtask

////////////////////
// Compare tasks
////////////////////

task automatic check_bit(input string name, input logic got, input logic exp);
   check_count++;
   if (got !== exp) begin
      error_count++;
      $display("ERROR %s got %h exp %h", name, got, exp);
   end
endtask

// Payload only matters on a valid packet
task automatic check_fetch(input string name, input if_id_t got, input if_id_t exp);
   check_count++;
   if (got.valid !== exp.valid) begin
      error_count++;
      $display("ERROR %s.valid got %h exp %h", name, got.valid, exp.valid);
   end else if (exp.valid && got !== exp) begin
      error_count++;
      $display("ERROR %s got pc %h pc4 %h inst %h exp pc %h pc4 %h inst %h",
               name, got.pc, got.pc4, got.inst, exp.pc, exp.pc4, exp.inst);
   end
endtask

`default_nettype wire

`endif

// ==== bench/ifetch_tb.sv ====
`default_nettype none

module ifetch_tb;

   import fetch_pkg::*;

   // Squashed or idle slot
   localparam if_id_t NO_PKT = '0;

   logic             clk;
   logic             rstn;
   logic             pause;
   ex_mem_redirect_t redirect;
   logic             upg_rst;
   logic             upg_done;
   upg_req_t         upg;
   if_id_t           fetch;
   logic             flush;

   // Uploaded program image
   word_t img [32];
   // PC of the packet now on fetch_o
   word_t exp_pc;
   int    error_count;
   int    check_count;

   ifetch dut0 (
      .clk        (clk),
      .rstn       (rstn),
      .pause_i    (pause),
      .redirect_i (redirect),
      .upg_rst_i  (upg_rst),
      .upg_done_i (upg_done),
      .upg_i      (upg),
      .fetch_o    (fetch),
      .flush_o    (flush)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   // One cycle redirect, one squashed slot, then the target
   task automatic redirect_and_check(input ex_mem_redirect_t rd, input word_t target);
      redirect = rd;
      #30;
      check_bit("flush_o", flush, 1'b1);
      tick();
      redirect = '0;
      check_fetch("fetch_o", fetch, NO_PKT);
      tick();
      check_fetch("fetch_o", fetch, make_pkt(target));
      tick();
      check_fetch("fetch_o", fetch, make_pkt(target + 32'd4));
      exp_pc = target + 32'd4;
   endtask

   ////////////////////
   // Directed tests
   ////////////////////

   task automatic test_reset();
      tick();
      // Taken jump held through reset
      redirect = make_redirect(4'b0010, '0, 32'h40, '0);
      repeat (15) tick();
      check_fetch("fetch_o", fetch, NO_PKT);
      check_bit("flush_o", flush, 1'b0);
      rstn = 1'b1;
      #30;
      check_bit("flush_o", flush, 1'b0);
      // First cycle out of reset still idle
      tick();
      redirect = '0;
      check_fetch("fetch_o", fetch, NO_PKT);
   endtask

   task automatic test_upload_seq();
      int i;
      upg_rst  = 1'b0;
      upg_done = 1'b0;
      repeat (2) tick();
      for (i = 0; i < 32; i++) begin
         img[i]  = $urandom();
         upg.wen = 1'b1;
         upg.adr = upg_addr_t'(i);
         upg.dat = img[i];
         tick();
      end
      upg = '0;
      // Let the last write land
      repeat (2) tick();
      check_fetch("fetch_o", fetch, NO_PKT);
      upg_done = 1'b1;
      wait_valid(8);
      for (i = 0; i < 32; i++) begin
         check_fetch("fetch_o", fetch, make_pkt(word_t'(i * 4)));
         if (i < 31) begin
            tick();
         end
      end
      exp_pc = 32'h7c;
   endtask

   task automatic test_branch();
      // Taken, target is mem_pc plus imm32
      redirect_and_check(make_redirect(4'b1100, '0, 32'h20, 32'h10), 32'h10 + 32'h20);
      // Zero low, straight on
      redirect = make_redirect(4'b1000, '0, 32'h20, 32'h10);
      #30;
      check_bit("flush_o", flush, 1'b0);
      tick();
      redirect = '0;
      exp_pc   = exp_pc + 32'd4;
      check_fetch("fetch_o", fetch, make_pkt(exp_pc));
   endtask

   task automatic test_jump();
      // Negative offset
      redirect_and_check(make_redirect(4'b0010, '0, 32'hffff_ffc8, 32'h40),
                         32'h40 + 32'hffff_ffc8);
      redirect_and_check(make_redirect(4'b0001, 32'h4d, '0, '0), 32'h4d & ~32'h1);
      // Jump and jalr together
      redirect_and_check(make_redirect(4'b0011, 32'h11, 32'h44, 32'h20), 32'h20 + 32'h44);
   endtask

   task automatic test_pause();
      pause = 1'b1;
      repeat (5) begin
         tick();
         check_fetch("fetch_o", fetch, make_pkt(exp_pc));
      end
      pause = 1'b0;
      tick();
      exp_pc = exp_pc + 32'd4;
      check_fetch("fetch_o", fetch, make_pkt(exp_pc));
      // Jump while stalled
      pause = 1'b1;
      tick();
      redirect = make_redirect(4'b0010, '0, 32'h14, 32'h0);
      #30;
      check_bit("flush_o", flush, 1'b1);
      tick();
      redirect = '0;
      repeat (3) begin
         check_fetch("fetch_o", fetch, NO_PKT);
         tick();
      end
      pause = 1'b0;
      wait_valid(4);
      check_fetch("fetch_o", fetch, make_pkt(32'h14));
      tick();
      check_fetch("fetch_o", fetch, make_pkt(32'h18));
      exp_pc = 32'h18;
   endtask

   task automatic test_filter_restart();
      int i;
      upg_done = 1'b0;
      repeat (2) tick();
      check_fetch("fetch_o", fetch, NO_PKT);
      // Data region aliases of words 3 and 5
      upg.wen = 1'b1;
      upg.adr = 15'h4003;
      upg.dat = ~img[3];
      tick();
      upg.adr = 15'h4005;
      upg.dat = ~img[5];
      tick();
      upg = '0;
      // Redirect while uploading
      redirect = make_redirect(4'b0010, '0, 32'h40, 32'h0);
      repeat (4) begin
         #30;
         check_bit("flush_o", flush, 1'b0);
         tick();
         check_fetch("fetch_o", fetch, NO_PKT);
      end
      redirect = '0;
      tick();
      upg_done = 1'b1;
      wait_valid(8);
      // Back at the boot address with the old words
      for (i = 0; i < 6; i++) begin
         check_fetch("fetch_o", fetch, make_pkt(word_t'(i * 4)));
         if (i < 5) begin
            tick();
         end
      end
   endtask

   ////////////////////
   // Sequence
   ////////////////////

   initial begin
      void'($urandom(53830));
      error_count = 0;
      check_count = 0;
      exp_pc      = '0;
      rstn        = 1'b0;
      pause       = 1'b0;
      redirect    = '0;
      upg_rst     = 1'b1;
      upg_done    = 1'b0;
      upg         = '0;
      test_reset();
      test_upload_seq();
      test_branch();
      test_jump();
      test_pause();
      test_filter_restart();
      $display("Checks %0d, errors %0d", check_count, error_count);
      if (error_count == 0) begin
         $display("Testbench passed");
      end else begin
         $display("Testbench failed");
      end
      $finish;
   end

`include "ifetch_tb_checks.svh"

endmodule

`default_nettype wire

// ==== ifetch.f ====
+incdir+bench
src/fetch_pkg.sv
src/pc_gen.sv
src/inst_mem.sv
src/prog_loader.sv
src/ifetch.sv
bench/ifetch_tb.sv

// ==== src/fetch_pkg.sv ====
`default_nettype none

package fetch_pkg;

   ////////////////////
   // Widths
   ////////////////////

   // Instruction, PC and data words
   localparam int unsigned WORD_W = 32;

   // Upload address, data region flag on top
   localparam int unsigned UPG_AW = 15;
   localparam int unsigned UPG_DATA_BIT = 14;

   // Sequential PC increment
   localparam logic [WORD_W-1:0] PC_STEP = 32'd4;

   typedef logic [WORD_W-1:0] word_t;
   typedef logic [UPG_AW-1:0] upg_addr_t;

   ////////////////////
   // Packets
   ////////////////////

   // Redirect fields from the EX/MEM register
   typedef struct packed {
      logic  branch;
      logic  zero;
      logic  jump;
      logic  jalr;
      word_t alu_result;
      word_t imm32;
      word_t mem_pc;
   } ex_mem_redirect_t;

   // Fetch output toward IF/ID
   typedef struct packed {
      logic  valid;
      word_t pc;
      word_t pc4;
      word_t inst;
   } if_id_t;

   // One upload write
   typedef struct packed {
      logic      wen;
      upg_addr_t adr;
      word_t     dat;
   } upg_req_t;

   // Loader modes
   typedef enum logic {
      LD_PROGRAM = 1'b0,
      LD_RUN     = 1'b1
   } loader_state_t;

endpackage

`default_nettype wire

// ==== src/ifetch.sv ====
`default_nettype none

module ifetch #(
   parameter int IMEM_AW = 14,
   parameter fetch_pkg::word_t RESET_PC = '0
) (
   input  logic                          clk,
   input  logic                          rstn,
   input  logic                          pause_i,
   input  fetch_pkg::ex_mem_redirect_t   redirect_i,
   input  logic                          upg_rst_i,
   input  logic                          upg_done_i,
   input  fetch_pkg::upg_req_t           upg_i,
   output fetch_pkg::if_id_t             fetch_o,
   output logic                          flush_o
);

   import fetch_pkg::*;

   ////////////////////
   // Internal nets
   ////////////////////

   // Upload side into the RAM
   logic               imem_we;
   logic [IMEM_AW-1:0] imem_waddr;
   word_t              imem_wdata;

   // Fetch side
   logic [IMEM_AW-1:0] imem_raddr;
   word_t              imem_rdata;

   // Mode control toward the PC
   logic run;
   logic restart;

   ////////////////////
   // Blocks
   ////////////////////

   prog_loader #(
      .IMEM_AW (IMEM_AW)
   ) u_loader (
      .clk          (clk),
      .rstn         (rstn),
      .upg_rst_i    (upg_rst_i),
      .upg_done_i   (upg_done_i),
      .upg_i        (upg_i),
      .imem_we_o    (imem_we),
      .imem_waddr_o (imem_waddr),
      .imem_wdata_o (imem_wdata),
      .run_o        (run),
      .restart_o    (restart)
   );

   inst_mem #(
      .IMEM_AW (IMEM_AW)
   ) u_imem (
      .clk     (clk),
      .we_i    (imem_we),
      .waddr_i (imem_waddr),
      .wdata_i (imem_wdata),
      .raddr_i (imem_raddr),
      .rdata_o (imem_rdata)
   );

   // PC, redirect and packet alignment
   pc_gen #(
      .IMEM_AW  (IMEM_AW),
      .RESET_PC (RESET_PC)
   ) u_pc (
      .clk          (clk),
      .rstn         (rstn),
      .run_i        (run),
      .restart_i    (restart),
      .pause_i      (pause_i),
      .redirect_i   (redirect_i),
      .imem_raddr_o (imem_raddr),
      .imem_rdata_i (imem_rdata),
      .fetch_o      (fetch_o),
      .flush_o      (flush_o)
   );

endmodule

`default_nettype wire

// ==== src/inst_mem.sv ====
`default_nettype none

module inst_mem #(
   parameter int IMEM_AW = 14
) (
   input  logic                 clk,
   input  logic                 we_i,
   input  logic [IMEM_AW-1:0]   waddr_i,
   input  fetch_pkg::word_t     wdata_i,
   input  logic [IMEM_AW-1:0]   raddr_i,
   output fetch_pkg::word_t     rdata_o
);

   import fetch_pkg::*;

   localparam int DEPTH = 2 ** IMEM_AW;

   // Block RAM array, contents survive reset
   word_t mem [DEPTH];

   logic [IMEM_AW-1:0] addr;
   word_t              rdata_q;

   // Single address port
   // Write address on a write cycle, fetch address otherwise
   assign addr = we_i ? waddr_i : raddr_i;

   always_ff @(posedge clk) begin
      if (we_i) begin
         mem[addr] <= wdata_i;
      end
   end

   // Registered read, old data on a write cycle
   always_ff @(posedge clk) begin
      rdata_q <= mem[addr];
   end

   assign rdata_o = rdata_q;

endmodule

`default_nettype wire

// ==== src/pc_gen.sv ====
`default_nettype none

module pc_gen #(
   parameter int IMEM_AW = 14,
   parameter fetch_pkg::word_t RESET_PC = '0
) (
   input  logic                          clk,
   input  logic                          rstn,
   input  logic                          run_i,
   input  logic                          restart_i,
   input  logic                          pause_i,
   input  fetch_pkg::ex_mem_redirect_t   redirect_i,
   output logic [IMEM_AW-1:0]            imem_raddr_o,
   input  fetch_pkg::word_t              imem_rdata_i,
   output fetch_pkg::if_id_t             fetch_o,
   output logic                          flush_o
);

   import fetch_pkg::*;

   // PC currently being issued to memory
   word_t pc_q;
   // PC of the instruction now on the memory output
   word_t pkt_pc_q;
   logic  pkt_valid_q;

   logic  take_bj;
   logic  taken;
   logic  hold;
   word_t target;

   ////////////////////
   // Redirect decode
   ////////////////////

   // Taken branch or jump uses the PC relative target
   assign take_bj = (redirect_i.branch & redirect_i.zero) | redirect_i.jump;
   assign taken   = take_bj | redirect_i.jalr;

   // Branch and jump win over jalr
   assign target = take_bj ? (redirect_i.mem_pc + redirect_i.imm32)
                           : {redirect_i.alu_result[WORD_W-1:1], 1'b0};

   // Wrong path squash, only while running
   assign flush_o = run_i & taken;

   // Stall only without a redirect
   assign hold = pause_i & ~taken;

   ////////////////////
   // PC register
   ////////////////////

   always_ff @(posedge clk) begin
      if (!rstn) begin
         pc_q        <= RESET_PC;
         pkt_valid_q <= 1'b0;
      end else if (!run_i || restart_i) begin
         // Upload or restart, park at the boot address
         pc_q        <= RESET_PC;
         pkt_valid_q <= 1'b0;
      end else if (taken) begin
         // In-flight fetch is on the wrong path
         pc_q        <= target;
         pkt_valid_q <= 1'b0;
      end else if (!pause_i) begin
         pc_q        <= pc_q + PC_STEP;
         pkt_valid_q <= 1'b1;
      end
   end

   // Follows the memory read by one cycle
   always_ff @(posedge clk) begin
      if (!hold) begin
         pkt_pc_q <= pc_q;
      end
   end

   ////////////////////
   // Memory side
   ////////////////////

   // On a stall re-read the word on the output so inst stays put
   assign imem_raddr_o = hold ? pkt_pc_q[IMEM_AW+1:2] : pc_q[IMEM_AW+1:2];

   // Instruction comes straight from the RAM output register
   assign fetch_o.valid = pkt_valid_q;
   assign fetch_o.pc    = pkt_pc_q;
   assign fetch_o.pc4   = pkt_pc_q + PC_STEP;
   assign fetch_o.inst  = imem_rdata_i;

   ////////////////////
   // Checks
   ////////////////////

   // Redirect targets must keep word alignment
   a_pc_aligned: assert property (
      @(posedge clk) disable iff (!rstn)
      pc_q[1:0] == 2'b00
   );

   // Restart comes with the first run cycle so no packet leaves for two cycles
   a_idle_after_prog: assert property (
      @(posedge clk) disable iff (!rstn)
      !run_i |=> !fetch_o.valid ##1 !fetch_o.valid
   );

endmodule

`default_nettype wire

// ==== src/prog_loader.sv ====
`default_nettype none

module prog_loader #(
   parameter int IMEM_AW = 14
) (
   input  logic                 clk,
   input  logic                 rstn,
   input  logic                 upg_rst_i,
   input  logic                 upg_done_i,
   input  fetch_pkg::upg_req_t  upg_i,
   output logic                 imem_we_o,
   output logic [IMEM_AW-1:0]   imem_waddr_o,
   output fetch_pkg::word_t     imem_wdata_o,
   output logic                 run_o,
   output logic                 restart_o
);

   import fetch_pkg::*;

   loader_state_t state_q;
   loader_state_t state_d;

   logic run_req;
   logic restart_q;

   // Registered upload write
   logic               wr_en_q;
   logic [IMEM_AW-1:0] wr_idx_q;
   word_t              wr_dat_q;

   ////////////////////
   // Mode FSM
   ////////////////////

   // Run while the uploader is held off or has finished
   assign run_req = upg_rst_i | upg_done_i;

   always_comb begin
      state_d = state_q;
      case (state_q)
         LD_PROGRAM: begin
            if (run_req) begin
               state_d = LD_RUN;
            end
         end
         LD_RUN: begin
            if (!run_req) begin
               state_d = LD_PROGRAM;
            end
         end
         default: state_d = LD_PROGRAM;
      endcase
   end

   // Out of reset the FSM steps into run with a restart when allowed
   always_ff @(posedge clk) begin
      if (!rstn) begin
         state_q   <= LD_PROGRAM;
         restart_q <= 1'b0;
      end else begin
         state_q   <= state_d;
         // One pulse on entry to run mode
         restart_q <= (state_q == LD_PROGRAM) && (state_d == LD_RUN);
      end
   end

   assign run_o     = (state_q == LD_RUN);
   assign restart_o = restart_q;

   ////////////////////
   // Write path
   ////////////////////

   // Data region words and run mode requests never reach the RAM
   always_ff @(posedge clk) begin
      if (!rstn) begin
         wr_en_q <= 1'b0;
      end else begin
         wr_en_q <= upg_i.wen & ~upg_i.adr[UPG_DATA_BIT] & ~run_req;
      end
   end

   // Word index is the low address bits
   always_ff @(posedge clk) begin
      wr_idx_q <= upg_i.adr[IMEM_AW-1:0];
      wr_dat_q <= upg_i.dat;
   end

   assign imem_we_o    = wr_en_q;
   assign imem_waddr_o = wr_idx_q;
   assign imem_wdata_o = wr_dat_q;

   // Write pipe and FSM must agree on the mode
   a_no_write_run: assert property (
      @(posedge clk) disable iff (!rstn)
      (state_q == LD_RUN) |-> !imem_we_o
   );

endmodule

`default_nettype wire
